/* common/qspis_macros.svh */
`ifndef QSPIS_MACROS_SVH
`define QSPIS_MACROS_SVH

//////////////////////////////
// Protocol widths
//////////////////////////////
`define QSPIS_ADDR_W      24 // Flash-style 3-byte address
`define QSPIS_DATA_W      32 // Register bus word
`define QSPIS_CMD_W       8  // Opcode byte
`define QSPIS_ADDR_STEP   4  // Byte step per word

//////////////////////////////
// Counters and timing
//////////////////////////////
`define QSPIS_CNT_W       6  // Bit counter, holds up to 32
`define QSPIS_DUMMY_FAST  8  // Dummy clocks of 0x0B
`define QSPIS_DUMMY_QIO   6  // Dummy clocks of 0xEB
`define QSPIS_SYNC_STAGES 3  // Pin synchronizer depth

`endif

/* common/qspis_pkg.sv */
`default_nettype none

`include "qspis_macros.svh"

package qspis_pkg;

   // Phase FSM
   typedef enum logic [2:0] {
      IDLE  = 3'd0, // Waiting for SSN low
      CMD   = 3'd1, // Opcode byte
      ADDR  = 3'd2, // 24-bit address
      DUMMY = 3'd3, // Turnaround clocks
      WRITE = 3'd4, // Data from host
      READ  = 3'd5, // Data to host
      EXIT  = 3'd6  // Parked until SSN high
   } spi_state_t;

   // Supported opcodes
   typedef enum logic [`QSPIS_CMD_W-1:0] {
      CMD_PAGE_PROG = 8'h02, // Single lane write
      CMD_READ      = 8'h03, // Single lane read
      CMD_FAST_READ = 8'h0B, // Single lane, 8 dummies
      CMD_QUAD_PROG = 8'h32, // Quad data write
      CMD_QIO_READ  = 8'hEB  // Quad addr and data, 6 dummies
   } spi_cmd_t;

   // Lanes used per rising edge
   typedef enum logic {
      LANE_SINGLE = 1'b0, // sdin[0] / sdout[0]
      LANE_QUAD   = 1'b1  // All four lines
   } lane_mode_t;

endpackage

`default_nettype wire

/* src/qspis_sync.sv */
`default_nettype none

`include "qspis_macros.svh"

module qspis_sync (
   input  wire       sys_clk,
   input  wire       rst_n,
   input  wire       sclk,      // Idles low in mode 0
   input  wire       ssn,
   input  wire [3:0] sdin,
   output logic      sclk_rise, // Sample strobe
   output logic      sclk_fall, // Launch strobe
   output logic      cs_active,
   output logic [3:0] sdin_s    // Aligned with sclk_rise
);

   localparam int S = `QSPIS_SYNC_STAGES;

   logic [S:0]      sclk_q; // Extra stage for edge compare
   logic [S-1:0]    ssn_q;
   logic            ssn_ss; // Debounced SSN
   logic [S:0][3:0] sdin_q; // Same depth as sclk_q

   //////////////////////////////
   // SCLK edge detect
   //////////////////////////////
   always_ff @(posedge sys_clk or negedge rst_n) begin
      if (!rst_n) begin
         sclk_q    <= '0; // Clock idles low
         sclk_rise <= 1'b0;
         sclk_fall <= 1'b0;
      end else begin
         sclk_q    <= {sclk_q[S-1:0], sclk};
         sclk_rise <= sclk_q[S-1] & ~sclk_q[S]; // Registered one-cycle pulse
         sclk_fall <= ~sclk_q[S-1] & sclk_q[S];
      end
   end

   // Data pins ride along with SCLK
   always_ff @(posedge sys_clk) begin
      sdin_q <= {sdin_q[S-1:0], sdin};
   end

   assign sdin_s = sdin_q[S]; // Pin value from the edge sample

   //////////////////////////////
   // SSN sync and debounce
   //////////////////////////////
   always_ff @(posedge sys_clk or negedge rst_n) begin
      if (!rst_n) begin
         ssn_q  <= '1; // Deselected
         ssn_ss <= 1'b1;
      end else begin
         ssn_q <= {ssn_q[S-2:0], ssn};
         if (ssn_q[S-1] == ssn_q[S-2]) begin // Two equal samples
            ssn_ss <= ssn_q[S-1];
         end
      end
   end

   assign cs_active = ~ssn_ss;

endmodule

`default_nettype wire

/* qspis_core/qspis_ctrl.sv */
`default_nettype none

`include "qspis_macros.svh"

module qspis_ctrl
   import qspis_pkg::*;
(
   input  wire        sys_clk,
   input  wire        rst_n,
   input  wire        sclk_rise,
   input  wire        cs_active,
   input  spi_cmd_t   cmd_byte,  // From shift_in
   input  wire        reg_ack,
   output spi_state_t state,
   output lane_mode_t lane,      // Lanes of the current phase
   output logic       reg_wr,
   output logic       reg_rd,
   output logic       addr_step, // Address +4 strobe
   output logic       sdout_oen  // Active low
);

   logic [`QSPIS_CNT_W-1:0] bitcnt;     // Edges left in phase, minus one
   logic [`QSPIS_CNT_W-1:0] dummy_clks; // 0 means no dummy phase
   logic [`QSPIS_CNT_W-1:0] data_last;
   logic                    rise_d;     // Lets cmd_byte settle
   logic                    is_read;
   lane_mode_t              data_lane;

   // Bit count reload for one data word
   assign data_last = (data_lane == LANE_QUAD) ?
                      `QSPIS_CNT_W'(`QSPIS_DATA_W/4 - 1) :
                      `QSPIS_CNT_W'(`QSPIS_DATA_W - 1);

   //////////////////////////////
   // Phase FSM
   //////////////////////////////
   always_ff @(posedge sys_clk or negedge rst_n) begin
      if (!rst_n) begin
         state      <= IDLE;
         lane       <= LANE_SINGLE;
         data_lane  <= LANE_SINGLE;
         is_read    <= 1'b1;
         dummy_clks <= '0;
         bitcnt     <= `QSPIS_CNT_W'(`QSPIS_CMD_W - 1);
         rise_d     <= 1'b0;
         reg_wr     <= 1'b0;
         reg_rd     <= 1'b0;
         addr_step  <= 1'b0;
         sdout_oen  <= 1'b1;
      end else begin
         rise_d    <= sclk_rise;
         addr_step <= 1'b0; // Single-cycle strobe
         if (!cs_active) begin // SSN high aborts everything
            state     <= IDLE;
            lane      <= LANE_SINGLE;
            bitcnt    <= `QSPIS_CNT_W'(`QSPIS_CMD_W - 1);
            reg_wr    <= 1'b0;
            reg_rd    <= 1'b0;
            sdout_oen <= 1'b1;
         end else begin
            case (state)
               IDLE: begin
                  state <= CMD;
               end
               CMD: begin
                  if (rise_d) begin
                     if (bitcnt == '0) begin
                        // Defaults, single-lane address
                        state      <= ADDR;
                        lane       <= LANE_SINGLE;
                        data_lane  <= LANE_SINGLE;
                        is_read    <= 1'b1;
                        dummy_clks <= '0;
                        bitcnt     <= `QSPIS_CNT_W'(`QSPIS_ADDR_W - 1);
                        case (cmd_byte)
                           CMD_READ: ;
                           CMD_FAST_READ: dummy_clks <= `QSPIS_CNT_W'(`QSPIS_DUMMY_FAST);
                           CMD_QIO_READ: begin
                              lane       <= LANE_QUAD; // Quad address too
                              data_lane  <= LANE_QUAD;
                              dummy_clks <= `QSPIS_CNT_W'(`QSPIS_DUMMY_QIO);
                              bitcnt     <= `QSPIS_CNT_W'(`QSPIS_ADDR_W/4 - 1);
                           end
                           CMD_PAGE_PROG: is_read <= 1'b0;
                           CMD_QUAD_PROG: begin
                              is_read   <= 1'b0;
                              data_lane <= LANE_QUAD;
                           end
                           default: state <= EXIT; // Unsupported, no bus access
                        endcase
                     end else begin
                        bitcnt <= bitcnt - 1'b1;
                     end
                  end
               end
               ADDR, DUMMY: begin
                  if (sclk_rise) begin
                     if (bitcnt != '0) begin
                        bitcnt <= bitcnt - 1'b1;
                     end else if (state == ADDR && dummy_clks != '0) begin
                        state  <= DUMMY;
                        lane   <= data_lane;
                        bitcnt <= dummy_clks - 1'b1;
                     end else begin
                        lane   <= data_lane;
                        bitcnt <= data_last;
                        if (is_read) begin
                           state     <= READ;
                           reg_rd    <= 1'b1; // Fetch first word now
                           sdout_oen <= 1'b0;
                        end else begin
                           state <= WRITE;
                        end
                     end
                  end
               end
               WRITE, READ: begin
                  if (reg_ack && (reg_wr || reg_rd)) begin
                     reg_wr    <= 1'b0;
                     reg_rd    <= 1'b0;
                     addr_step <= 1'b1;
                  end
                  if (sclk_rise) begin
                     if (bitcnt == '0) begin // Word boundary
                        reg_wr <= ~is_read; // Word complete
                        reg_rd <= is_read;  // Prefetch next word
                        bitcnt <= data_last;
                     end else begin
                        bitcnt <= bitcnt - 1'b1;
                     end
                  end
               end
               EXIT: ; // Hold until SSN high
               default: state <= IDLE;
            endcase
         end
      end
   end

   //////////////////////////////
   // Bus protocol checks
   //////////////////////////////
   a_req_excl: assert property (@(posedge sys_clk) disable iff (!rst_n)
      !(reg_wr && reg_rd))
      else $error("reg_wr and reg_rd both high");

   a_rd_state: assert property (@(posedge sys_clk) disable iff (!rst_n)
      reg_rd |-> state inside {DUMMY, READ})
      else $error("reg_rd outside read phase");

   a_wr_state: assert property (@(posedge sys_clk) disable iff (!rst_n)
      reg_wr |-> state == WRITE)
      else $error("reg_wr outside write phase");

   // Request drops on the ack cycle
   a_ack_drop: assert property (@(posedge sys_clk) disable iff (!rst_n)
      reg_ack |=> !(reg_wr || reg_rd))
      else $error("request held after reg_ack");

endmodule

`default_nettype wire

/* qspis_core/qspis_shift_in.sv */
`default_nettype none

`include "qspis_macros.svh"

module qspis_shift_in
   import qspis_pkg::*;
(
   input  wire                       sys_clk,
   input  wire                       rst_n,
   input  wire                       sclk_rise,
   input  wire  [3:0]                sdin_s,
   input  spi_state_t                state,
   input  lane_mode_t                lane,
   input  wire                       addr_step,
   output spi_cmd_t                  cmd_byte,
   output logic [`QSPIS_ADDR_W-1:0]  reg_addr,
   output logic [`QSPIS_DATA_W-1:0]  reg_wdata
);

   logic [`QSPIS_CMD_W-1:0] cmd_q;

   //////////////////////////////
   // Opcode, always single lane
   //////////////////////////////
   always_ff @(posedge sys_clk or negedge rst_n) begin
      if (!rst_n) begin
         cmd_q <= '0;
      end else if (sclk_rise && state == CMD) begin
         cmd_q <= {cmd_q[`QSPIS_CMD_W-2:0], sdin_s[0]}; // MSB first
      end
   end

   assign cmd_byte = spi_cmd_t'(cmd_q); // Unknown codes pass through

   //////////////////////////////
   // Address and increment
   //////////////////////////////
   always_ff @(posedge sys_clk) begin
      if (sclk_rise && state == ADDR) begin
         if (lane == LANE_QUAD) begin // 0xEB only
            reg_addr <= {reg_addr[`QSPIS_ADDR_W-5:0], sdin_s};
         end else begin
            reg_addr <= {reg_addr[`QSPIS_ADDR_W-2:0], sdin_s[0]};
         end
      end else if (addr_step) begin // After each ack
         reg_addr <= reg_addr + `QSPIS_ADDR_W'(`QSPIS_ADDR_STEP);
      end
   end

   // Write data, held stable while reg_wr is up
   always_ff @(posedge sys_clk) begin
      if (sclk_rise && state == WRITE) begin
         if (lane == LANE_QUAD) begin
            reg_wdata <= {reg_wdata[`QSPIS_DATA_W-5:0], sdin_s}; // sdin[3] is MSB
         end else begin
            reg_wdata <= {reg_wdata[`QSPIS_DATA_W-2:0], sdin_s[0]};
         end
      end
   end

endmodule

`default_nettype wire

/* qspis_core/qspis_shift_out.sv */
`default_nettype none

`include "qspis_macros.svh"

module qspis_shift_out
   import qspis_pkg::*;
(
   input  wire                      sys_clk,
   input  wire                      rst_n,
   input  wire                      sclk_fall,
   input  spi_state_t               state,
   input  lane_mode_t               lane,
   input  wire                      reg_ack,
   input  wire [`QSPIS_DATA_W-1:0]  reg_rdata,
   output logic [3:0]               sdout
);

   logic [`QSPIS_DATA_W-1:0] rd_shift;  // Word being sent
   logic [`QSPIS_CNT_W-1:0]  bits_left; // Bits not yet driven

   // Payload shifter, MSB leaves first
   always_ff @(posedge sys_clk) begin
      if (reg_ack) begin
         rd_shift <= reg_rdata;
      end else if (state == READ && sclk_fall) begin
         if (lane == LANE_QUAD) begin
            rd_shift <= {rd_shift[`QSPIS_DATA_W-5:0], 4'b0000};
         end else begin
            rd_shift <= {rd_shift[`QSPIS_DATA_W-2:0], 1'b0};
         end
      end
   end

   //////////////////////////////
   // Pin drive on falling edge
   //////////////////////////////
   always_ff @(posedge sys_clk or negedge rst_n) begin
      if (!rst_n) begin
         sdout <= 4'b0000;
      end else if (state == READ && sclk_fall) begin
         if (lane == LANE_QUAD) begin
            sdout <= rd_shift[`QSPIS_DATA_W-1 -: 4]; // Top nibble
         end else begin
            sdout <= {3'b111, rd_shift[`QSPIS_DATA_W-1]}; // Spare lines high
         end
      end
   end

   // Tracks word progress for the ack check
   always_ff @(posedge sys_clk or negedge rst_n) begin
      if (!rst_n) begin
         bits_left <= '0;
      end else if (state == IDLE) begin
         bits_left <= '0;
      end else if (reg_ack) begin
         bits_left <= `QSPIS_CNT_W'(`QSPIS_DATA_W);
      end else if (state == READ && sclk_fall && bits_left != '0) begin
         bits_left <= bits_left - ((lane == LANE_QUAD) ? `QSPIS_CNT_W'(4) : `QSPIS_CNT_W'(1));
      end
   end

   // Prefetch must land between words
   a_ack_word: assert property (@(posedge sys_clk) disable iff (!rst_n)
      (reg_ack && state == READ) |-> bits_left == '0)
      else $error("reg_ack in the middle of a read word");

endmodule

`default_nettype wire

/* src/qspis_top.sv */
`default_nettype none

`include "qspis_macros.svh"

module qspis_top
   import qspis_pkg::*;
(
   input  wire                      sys_clk,
   input  wire                      rst_n,
   // SPI pins
   input  wire                      sclk,
   input  wire                      ssn,
   input  wire  [3:0]               sdin,
   output logic [3:0]               sdout,
   output logic                     sdout_oen, // Active low
   // Register bus
   output logic                     reg_wr,
   output logic                     reg_rd,
   output logic [`QSPIS_ADDR_W-1:0] reg_addr,
   output logic [`QSPIS_DATA_W-1:0] reg_wdata,
   input  wire  [`QSPIS_DATA_W-1:0] reg_rdata,
   input  wire                      reg_ack
);

   logic       sclk_rise;
   logic       sclk_fall;
   logic       cs_active;
   logic [3:0] sdin_s;
   logic       addr_step;
   spi_state_t state;
   lane_mode_t lane;
   spi_cmd_t   cmd_byte;

   //////////////////////////////
   // Pin synchronizer
   //////////////////////////////
   qspis_sync qspis_sync_inst (
      .sys_clk   (sys_clk),
      .rst_n     (rst_n),
      .sclk      (sclk),
      .ssn       (ssn),
      .sdin      (sdin),
      .sclk_rise (sclk_rise),
      .sclk_fall (sclk_fall),
      .cs_active (cs_active),
      .sdin_s    (sdin_s)
   );

   // Phase control and bus requests
   qspis_ctrl qspis_ctrl_inst (
      .sys_clk   (sys_clk),
      .rst_n     (rst_n),
      .sclk_rise (sclk_rise),
      .cs_active (cs_active),
      .cmd_byte  (cmd_byte),
      .reg_ack   (reg_ack),
      .state     (state),
      .lane      (lane),
      .reg_wr    (reg_wr),
      .reg_rd    (reg_rd),
      .addr_step (addr_step),
      .sdout_oen (sdout_oen)
   );

   //////////////////////////////
   // Datapath
   //////////////////////////////
   qspis_shift_in qspis_shift_in_inst (
      .sys_clk   (sys_clk),
      .rst_n     (rst_n),
      .sclk_rise (sclk_rise),
      .sdin_s    (sdin_s),
      .state     (state),
      .lane      (lane),
      .addr_step (addr_step),
      .cmd_byte  (cmd_byte),
      .reg_addr  (reg_addr),
      .reg_wdata (reg_wdata)
   );

   qspis_shift_out qspis_shift_out_inst (
      .sys_clk   (sys_clk),
      .rst_n     (rst_n),
      .sclk_fall (sclk_fall),
      .state     (state),
      .lane      (lane),
      .reg_ack   (reg_ack),
      .reg_rdata (reg_rdata),
      .sdout     (sdout)
   );

endmodule

`default_nettype wire

/* sim/tb_qspis.sv */
`default_nettype none

`include "qspis_macros.svh"

module tb_qspis
   import qspis_pkg::*;
();

   localparam int CLK_PERIOD    = 10;
   localparam int HALF_SCLK     = 8;   // sys_clk cycles per SCLK half
   localparam int NUM_TRANS     = 15;
   localparam int TRANS_SCLKS   = 200; // 4-word single-lane write plus framing
   localparam int WATCHDOG_TIME = NUM_TRANS * TRANS_SCLKS * 2 * HALF_SCLK * CLK_PERIOD;

   logic                     sys_clk = 1'b0;
   logic                     rst_n;
   logic                     sclk;
   logic                     ssn;
   logic [3:0]               sdin;
   logic [3:0]               sdout;
   logic                     sdout_oen;
   logic                     reg_wr;
   logic                     reg_rd;
   logic [`QSPIS_ADDR_W-1:0] reg_addr;
   logic [`QSPIS_DATA_W-1:0] reg_wdata;
   logic [`QSPIS_DATA_W-1:0] reg_rdata = '0;
   logic                     reg_ack   = 1'b0;

   // Reference side written by the host process
   logic [`QSPIS_DATA_W-1:0] model_mem [bit [`QSPIS_ADDR_W-1:0]];
   logic [`QSPIS_ADDR_W-1:0] exp_wr_addr [$];
   logic [`QSPIS_DATA_W-1:0] exp_wr_data [$];
   logic [`QSPIS_ADDR_W-1:0] exp_rd_addr [$];
   logic [`QSPIS_ADDR_W-1:0] last_base;
   int                       host_errs = 0;

   // Bus side owned by the responder
   logic [`QSPIS_DATA_W-1:0] bus_mem [bit [`QSPIS_ADDR_W-1:0]];
   int                       wr_seen  = 0;
   int                       rd_seen  = 0;
   int                       bus_errs = 0;
   int                       oen_low_cycles = 0;

   always #(CLK_PERIOD/2) sys_clk = ~sys_clk;

   qspis_top qspis_top_inst (
      .sys_clk   (sys_clk),
      .rst_n     (rst_n),
      .sclk      (sclk),
      .ssn       (ssn),
      .sdin      (sdin),
      .sdout     (sdout),
      .sdout_oen (sdout_oen),
      .reg_wr    (reg_wr),
      .reg_rd    (reg_rd),
      .reg_addr  (reg_addr),
      .reg_wdata (reg_wdata),
      .reg_rdata (reg_rdata),
      .reg_ack   (reg_ack)
   );

   //////////////////////////////
   // Memory model helpers
   //////////////////////////////
   // Fill for unwritten locations uses every address bit
   function automatic logic [`QSPIS_DATA_W-1:0] fill_word(input logic [`QSPIS_ADDR_W-1:0] a);
      return {a[7:0], a} ^ 32'h5ac3_9e17;
   endfunction

   function automatic logic [`QSPIS_ADDR_W-1:0] rand_addr();
      logic [31:0] r;
      r = $urandom;
      return r[`QSPIS_ADDR_W-1:0];
   endfunction

   function automatic int rand_words();
      return int'($urandom_range(4, 1)); // 1 to 4 words
   endfunction

   function automatic logic [`QSPIS_ADDR_W-1:0] word_addr(input logic [`QSPIS_ADDR_W-1:0] base,
                                                          input int idx);
      return base + `QSPIS_ADDR_W'(`QSPIS_ADDR_STEP * idx);
   endfunction

   //////////////////////////////
   // Register bus responder
   //////////////////////////////
   always begin : bus_responder
      int unsigned              lat;
      logic [`QSPIS_ADDR_W-1:0] a;
      @(negedge sys_clk);
      if (rst_n === 1'b1 && (reg_wr === 1'b1 || reg_rd === 1'b1)) begin
         a = reg_addr;
         if (reg_wr === 1'b1) begin
            if (wr_seen >= exp_wr_addr.size()) begin
               $display("Unexpected bus write at address %06h", a);
               bus_errs++;
            end else begin
               if (a !== exp_wr_addr[wr_seen]) begin
                  $display("ERR reg_addr expected %06h got %06h", exp_wr_addr[wr_seen], a);
                  bus_errs++;
               end
               if (reg_wdata !== exp_wr_data[wr_seen]) begin
                  $display("ERR reg_wdata expected %08h got %08h",
                           exp_wr_data[wr_seen], reg_wdata);
                  bus_errs++;
               end
            end
            wr_seen++;
            bus_mem[a] = reg_wdata;
         end else begin
            if (rd_seen >= exp_rd_addr.size()) begin
               $display("Unexpected bus read at address %06h", a);
               bus_errs++;
            end else if (a !== exp_rd_addr[rd_seen]) begin
               $display("ERR reg_addr expected %06h got %06h", exp_rd_addr[rd_seen], a);
               bus_errs++;
            end
            rd_seen++;
         end
         lat = $urandom_range(3, 1); // Ack after 1 to 3 cycles
         repeat (lat - 1) @(negedge sys_clk);
         if (reg_wr === 1'b1 || reg_rd === 1'b1) begin // SSN may have cleared it
            reg_rdata = bus_mem.exists(a) ? bus_mem[a] : fill_word(a);
            reg_ack   = 1'b1;
            @(negedge sys_clk);
            reg_ack   = 1'b0;
         end
      end
   end

   always @(negedge sys_clk) begin
      if (sdout_oen === 1'b0) oen_low_cycles = oen_low_cycles + 1; // Output enable seen
   end

   //////////////////////////////
   // SPI host, mode 0
   //////////////////////////////
   task automatic spi_begin();
      @(negedge sys_clk);
      ssn  = 1'b0;
      sdin = 4'h0;
      repeat (2 * HALF_SCLK) @(negedge sys_clk); // Debounce plus IDLE to CMD
   endtask

   task automatic spi_end();
      @(negedge sys_clk);
      sclk = 1'b0; // Back to idle low
      repeat (HALF_SCLK) @(negedge sys_clk);
      ssn = 1'b1;
      repeat (2 * HALF_SCLK) @(negedge sys_clk);
   endtask

   // One SCLK per lane group with data out MSB first and sdout captured before each rise
   task automatic xfer(input logic [31:0] data, input int nbits, input bit quad,
                       output logic [31:0] rx);
      logic [31:0] sh;
      logic [3:0]  q;
      int          n;
      int          i;
      sh = data << (32 - nbits);
      n  = quad ? nbits / 4 : nbits;
      rx = '0;
      for (i = 0; i < n; i++) begin
         @(negedge sys_clk);
         sclk = 1'b0;
         sdin = quad ? sh[31:28] : {3'b000, sh[31]};
         sh   = quad ? (sh << 4) : (sh << 1);
         repeat (HALF_SCLK) @(negedge sys_clk);
         q    = sdout;
         sclk = 1'b1;
         rx   = quad ? {rx[27:0], q} : {rx[30:0], q[0]};
         repeat (HALF_SCLK - 1) @(negedge sys_clk);
      end
   endtask

   task automatic check_bus_drained();
      if (wr_seen != exp_wr_addr.size() || rd_seen != exp_rd_addr.size()) begin
         $display("Bus access count wrong, %0d of %0d writes and %0d of %0d reads seen",
                  wr_seen, exp_wr_addr.size(), rd_seen, exp_rd_addr.size());
         host_errs++;
      end
   endtask

   //////////////////////////////
   // Command sequences
   //////////////////////////////
   // Partial trailing word of extra_bits is cut by SSN and must not be written
   task automatic write_cmd(input logic [7:0] op, input int nwords, input int extra_bits);
      logic [`QSPIS_ADDR_W-1:0] base;
      logic [`QSPIS_ADDR_W-1:0] a;
      logic [31:0]              word;
      logic [31:0]              rx;
      bit                       quad;
      int                       i;
      quad = (op == CMD_QUAD_PROG);
      base = rand_addr();
      spi_begin();
      xfer(32'(op), `QSPIS_CMD_W, 1'b0, rx);
      xfer(32'(base), `QSPIS_ADDR_W, 1'b0, rx); // Address always single lane here
      for (i = 0; i < nwords; i++) begin
         word = $urandom;
         a    = word_addr(base, i);
         exp_wr_addr.push_back(a);
         exp_wr_data.push_back(word);
         model_mem[a] = word;
         xfer(word, `QSPIS_DATA_W, quad, rx);
      end
      if (extra_bits > 0) begin
         word = $urandom;
         xfer(word, extra_bits, quad, rx);
      end
      spi_end();
      check_bus_drained();
      last_base = base;
   endtask

   task automatic read_cmd(input logic [7:0] op, input logic [`QSPIS_ADDR_W-1:0] base,
                           input int nwords);
      logic [`QSPIS_ADDR_W-1:0] a;
      logic [31:0]              rx;
      logic [31:0]              expw;
      bit                       quad;
      int                       dummies;
      int                       i;
      quad = (op == CMD_QIO_READ);
      if (op == CMD_FAST_READ) begin
         dummies = `QSPIS_DUMMY_FAST;
      end else if (quad) begin
         dummies = `QSPIS_DUMMY_QIO;
      end else begin
         dummies = 0;
      end
      for (i = 0; i <= nwords; i++) begin
         exp_rd_addr.push_back(word_addr(base, i)); // Last one is the trailing prefetch
      end
      spi_begin();
      xfer(32'(op), `QSPIS_CMD_W, 1'b0, rx);
      xfer(32'(base), `QSPIS_ADDR_W, quad, rx);
      if (dummies > 0) xfer(32'h0, quad ? 4 * dummies : dummies, quad, rx);
      for (i = 0; i < nwords; i++) begin
         a    = word_addr(base, i);
         expw = model_mem.exists(a) ? model_mem[a] : fill_word(a);
         xfer(32'h0, `QSPIS_DATA_W, quad, rx);
         if (rx !== expw) begin
            $display("ERR sdout expected %08h got %08h (op %02h word %0d)", expw, rx, op, i);
            host_errs++;
         end
         if (!quad && sdout[3:1] !== 3'b111) begin // Spare lines in single mode
            $display("ERR sdout[3:1] expected %h got %h", 3'b111, sdout[3:1]);
            host_errs++;
         end
      end
      if (sdout_oen !== 1'b0) begin
         $display("ERR sdout_oen expected %h got %h", 1'b0, sdout_oen);
         host_errs++;
      end
      spi_end();
      if (sdout_oen !== 1'b1) begin // Released once SSN is high
         $display("ERR sdout_oen expected %h got %h", 1'b1, sdout_oen);
         host_errs++;
      end
      check_bus_drained();
   endtask

   //////////////////////////////
   // Test sequence
   //////////////////////////////
   initial begin : main
      logic [31:0] rx;
      int          i;
      int          oen_before;
      void'($urandom(32'he865a98f));
      rst_n     = 1'b0;
      sclk      = 1'b0;
      ssn       = 1'b1;
      sdin      = 4'h0;
      last_base = '0;
      repeat (8) @(negedge sys_clk);
      rst_n = 1'b1;
      repeat (2) @(negedge sys_clk);

      if (reg_wr !== 1'b0 || reg_rd !== 1'b0) begin
         $display("ERR reg_wr/reg_rd expected 0/0 got %h/%h", reg_wr, reg_rd);
         host_errs++;
      end
      if (sdout_oen !== 1'b1) begin
         $display("ERR sdout_oen expected %h got %h", 1'b1, sdout_oen);
         host_errs++;
      end
      if (sdout !== 4'h0) begin
         $display("ERR sdout expected %h got %h", 4'h0, sdout);
         host_errs++;
      end

      // Unsupported opcode parks the FSM in EXIT
      oen_before = oen_low_cycles;
      spi_begin();
      xfer(32'h06, `QSPIS_CMD_W, 1'b0, rx);
      xfer($urandom, `QSPIS_ADDR_W, 1'b0, rx);
      spi_end();
      check_bus_drained();
      if (oen_low_cycles != oen_before) begin
         $display("sdout_oen went low during an unsupported opcode");
         host_errs++;
      end

      for (i = 0; i < 3; i++) write_cmd(CMD_PAGE_PROG, rand_words(), 0);
      for (i = 0; i < 3; i++) write_cmd(CMD_QUAD_PROG, rand_words(), 0);

      // First pass reads back the last quad write
      for (i = 0; i < 2; i++) begin
         read_cmd(CMD_READ, (i == 0) ? last_base : rand_addr(), rand_words());
         read_cmd(CMD_FAST_READ, (i == 0) ? last_base : rand_addr(), rand_words());
         read_cmd(CMD_QIO_READ, (i == 0) ? last_base : rand_addr(), rand_words());
      end

      // SSN cut 13 bits into the second word
      write_cmd(CMD_PAGE_PROG, 1, 13);
      read_cmd(CMD_READ, last_base, 1);

      $display("Checks done, %0d bus errors, %0d host errors", bus_errs, host_errs);
      if (bus_errs + host_errs == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

   initial begin : watchdog
      #(WATCHDOG_TIME);
      $display("Watchdog timeout, the test sequence did not finish in time");
      $display("Test failed");
      $finish;
   end

endmodule

`default_nettype wire

/* files.f */
+incdir+common
common/qspis_pkg.sv
src/qspis_sync.sv
qspis_core/qspis_ctrl.sv
qspis_core/qspis_shift_in.sv
qspis_core/qspis_shift_out.sv
src/qspis_top.sv
sim/tb_qspis.sv

/* run.sh */
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f files.f --top-module tb_qspis -o sim_qspis
./obj_dir/sim_qspis | tee sim.log

if grep -q "Test failed" sim.log; then
   echo "Simulation reported a failure"
   exit 1
fi
echo "Simulation finished without failure"
